// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

    // word address width, one address per 32-bit word
    localparam int ADDR_W = 8;

    // data word width
    localparam int DATA_W = 32;

    // store buffer entries
    // keep this a power of two so the ring pointers wrap on their own
    localparam int SB_DEPTH = 8;

    // entry index width
    localparam int SB_IDX_W = $clog2(SB_DEPTH);

    // data ram covers the whole word address space
    localparam int RAM_WORDS = 1 << ADDR_W;

endpackage

// ==== hdl/store_buffer.sv ====
module store_buffer import lsu_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              issue_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic              commit_i,
    input  logic              wb_ack_i,
    output logic              full_o,
    output logic              fwd_hit_o,
    output logic [DATA_W-1:0] fwd_data_o,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output logic [DATA_W-1:0] wb_dat_o
);

    // entry storage
    logic [ADDR_W-1:0] ent_addr [SB_DEPTH];
    logic [DATA_W-1:0] ent_data [SB_DEPTH];
    logic [SB_DEPTH-1:0] ent_valid;
    logic [SB_DEPTH-1:0] ent_cmt;

    // ring pointers: head = oldest, cmt_ptr = oldest uncommitted, tail = next free
    logic [SB_IDX_W-1:0] head;
    logic [SB_IDX_W-1:0] cmt_ptr;
    logic [SB_IDX_W-1:0] tail;
    logic [SB_IDX_W:0]   count;

    logic              accept;
    logic              do_commit;
    logic              ld_search;
    logic              drain_start;
    logic              drain_done;
    logic              srch_hit;
    logic [DATA_W-1:0] srch_data;

    logic              wb_cyc_q;
    logic              wb_stb_q;
    logic [ADDR_W-1:0] wb_adr_q;
    logic [DATA_W-1:0] wb_dat_q;
    logic              fwd_hit_q;
    logic [DATA_W-1:0] fwd_data_q;

    assign full_o      = (count == (SB_IDX_W + 1)'(SB_DEPTH));
    assign accept      = issue_i && we_i && !full_o;
    assign ld_search   = issue_i && !we_i;
    assign do_commit   = commit_i && ent_valid[cmt_ptr] && !ent_cmt[cmt_ptr];
    // head entry goes out once the rob has committed it
    assign drain_start = !wb_cyc_q && ent_valid[head] && ent_cmt[head];
    assign drain_done  = wb_cyc_q && wb_ack_i;

    // walk oldest to youngest, last match wins
    // an entry being acked this cycle is still valid here
    always_comb begin
        logic [SB_IDX_W-1:0] idx;
        srch_hit  = 1'b0;
        srch_data = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            idx = head + SB_IDX_W'(i);
            if (ent_valid[idx] && ent_addr[idx] == addr_i) begin
                srch_hit  = 1'b1;
                srch_data = ent_data[idx];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head      <= '0;
            cmt_ptr   <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
            ent_cmt   <= '0;
            wb_cyc_q  <= 1'b0;
            wb_stb_q  <= 1'b0;
            fwd_hit_q <= 1'b0;
        end else begin
            if (accept) begin
                ent_valid[tail] <= 1'b1;
                ent_cmt[tail]   <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (do_commit) begin
                ent_cmt[cmt_ptr] <= 1'b1;
                cmt_ptr          <= cmt_ptr + 1'b1;
            end
            if (drain_start) begin
                wb_cyc_q <= 1'b1;
                wb_stb_q <= 1'b1;
            end
            // ack frees the head, cyc stays low for a cycle after
            if (drain_done) begin
                wb_cyc_q        <= 1'b0;
                wb_stb_q        <= 1'b0;
                ent_valid[head] <= 1'b0;
                ent_cmt[head]   <= 1'b0;
                head            <= head + 1'b1;
            end
            if (accept && !drain_done) begin
                count <= count + 1'b1;
            end else if (!accept && drain_done) begin
                count <= count - 1'b1;
            end
            fwd_hit_q <= ld_search && srch_hit;
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            ent_addr[tail] <= addr_i;
            ent_data[tail] <= wdata_i;
        end
        if (drain_start) begin
            wb_adr_q <= ent_addr[head];
            wb_dat_q <= ent_data[head];
        end
        fwd_data_q <= srch_data;
    end

    assign fwd_hit_o  = fwd_hit_q;
    assign fwd_data_o = fwd_data_q;
    assign wb_cyc_o   = wb_cyc_q;
    assign wb_stb_o   = wb_stb_q;
    // drain path only ever writes
    assign wb_we_o    = wb_cyc_q;
    assign wb_adr_o   = wb_adr_q;
    assign wb_dat_o   = wb_dat_q;

    // caller must hold off stores while full
    a_no_store_full: assert property (@(posedge clk_i) disable iff (reset_i)
        issue_i && we_i |-> !full_o)
        else $error("store issued while store buffer full, store dropped");

    a_commit_has_entry: assert property (@(posedge clk_i) disable iff (reset_i)
        commit_i |-> ent_valid[cmt_ptr] && !ent_cmt[cmt_ptr])
        else $error("commit with no uncommitted store");

    a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_stb_o |-> wb_cyc_o)
        else $error("wishbone stb without cyc");

endmodule

// ==== hdl/data_ram.sv ====
module data_ram import lsu_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output logic              wb_ack_o,
    output logic [DATA_W-1:0] rd_data_o
);

    // zero at simulation start
    logic [DATA_W-1:0] mem [RAM_WORDS] = '{default: '0};

    logic              ack_q;
    logic              wb_req;
    logic [DATA_W-1:0] rd_q;

    // strobe not acknowledged yet
    assign wb_req = wb_cyc_i && wb_stb_i && !ack_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_req;
        end
    end

    // word lands at the edge that raises ack
    always_ff @(posedge clk_i) begin
        if (wb_req && wb_we_i) begin
            mem[wb_adr_i] <= wb_dat_i;
        end
        rd_q <= mem[rd_addr_i];
    end

    assign wb_ack_o  = ack_q;
    assign rd_data_o = rd_q;

    a_ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("wishbone ack high two cycles in a row");

endmodule

// ==== hdl/load_merge.sv ====
module load_merge import lsu_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              ld_issue_i,
    input  logic              fwd_hit_i,
    input  logic [DATA_W-1:0] fwd_data_i,
    input  logic [DATA_W-1:0] ram_data_i,
    output logic              load_valid_o,
    output logic [DATA_W-1:0] load_data_o,
    output logic              load_fwd_o
);

    // load issue lined up with the two lookups
    logic              ld_pending;
    logic              valid_q;
    logic              fwd_q;
    logic [DATA_W-1:0] data_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ld_pending <= 1'b0;
            valid_q    <= 1'b0;
            fwd_q      <= 1'b0;
        end else begin
            ld_pending <= ld_issue_i;
            valid_q    <= ld_pending;
            // source flag only means something with valid
            fwd_q      <= ld_pending && fwd_hit_i;
        end
    end

    // buffered store data beats the ram copy
    always_ff @(posedge clk_i) begin
        if (ld_pending) begin
            data_q <= fwd_hit_i ? fwd_data_i : ram_data_i;
        end
    end

    assign load_valid_o = valid_q;
    assign load_data_o  = data_q;
    assign load_fwd_o   = fwd_q;

endmodule

// ==== hdl/lsu_top.sv ====
module lsu_top import lsu_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              issue_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic              commit_i,
    output logic              full_o,
    output logic              load_valid_o,
    output logic [DATA_W-1:0] load_data_o,
    output logic              load_fwd_o
);

    logic              ld_issue;

    // drain path
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat;
    logic              wb_ack;

    // load lookups, both registered
    logic              fwd_hit;
    logic [DATA_W-1:0] fwd_data;
    logic [DATA_W-1:0] ram_rdata;

    assign ld_issue = issue_i && !we_i;

    store_buffer u_store_buffer (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .issue_i    (issue_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .commit_i   (commit_i),
        .wb_ack_i   (wb_ack),
        .full_o     (full_o),
        .fwd_hit_o  (fwd_hit),
        .fwd_data_o (fwd_data),
        .wb_cyc_o   (wb_cyc),
        .wb_stb_o   (wb_stb),
        .wb_we_o    (wb_we),
        .wb_adr_o   (wb_adr),
        .wb_dat_o   (wb_dat)
    );

    data_ram u_data_ram (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_adr_i  (wb_adr),
        .wb_dat_i  (wb_dat),
        .rd_addr_i (addr_i),
        .wb_ack_o  (wb_ack),
        .rd_data_o (ram_rdata)
    );

    load_merge u_load_merge (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .ld_issue_i   (ld_issue),
        .fwd_hit_i    (fwd_hit),
        .fwd_data_i   (fwd_data),
        .ram_data_i   (ram_rdata),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o),
        .load_fwd_o   (load_fwd_o)
    );

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk_o
);

    // free running, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

// ==== tb/lsu_tb.sv ====
module lsu_tb import lsu_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int LOAD_LATENCY = 2;
    localparam int DIRECTED_OPS = 80;
    localparam int RANDOM_OPS   = 400;
    localparam int TOTAL_OPS    = DIRECTED_OPS + RANDOM_OPS;
    // longest a single wait may run before it counts as stuck
    localparam int WAIT_LIMIT   = 300;

    logic              clk;
    logic              reset;
    logic              issue;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              commit;
    logic              full;
    logic              load_valid;
    logic [DATA_W-1:0] load_data;
    logic              load_fwd;

    // reference model state
    logic [DATA_W-1:0] shadow_mem [RAM_WORDS];
    int                pend_cnt [RAM_WORDS];
    logic [DATA_W-1:0] exp_data_q [$];
    logic              exp_fwd_q [$];
    int                exp_cycle_q [$];
    logic [ADDR_W-1:0] used_addr_q [$];

    logic [31:0] lfsr_state = 32'h9632;
    int cycle_cnt     = 0;
    int acks_seen     = 0;
    int stores_driven = 0;
    int loads_driven  = 0;
    int loads_checked = 0;
    int uncommitted   = 0;
    int errors        = 0;
    int errors_before = 0;
    int tests_run     = 0;

    tb_clock #(.PERIOD(20)) u_clock (.clk_o(clk));

    lsu_top dut (
        .clk_i        (clk),
        .reset_i      (reset),
        .issue_i      (issue),
        .we_i         (we),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .commit_i     (commit),
        .full_o       (full),
        .load_valid_o (load_valid),
        .load_data_o  (load_data),
        .load_fwd_o   (load_fwd)
    );

    // taps 32 22 2 1
    function automatic logic lfsr_next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_next_bit()};
        end
        return v;
    endfunction

    // program order value, forwarded while a store to it is still buffered
    function automatic logic [DATA_W-1:0] expected_load(input logic [ADDR_W-1:0] a,
                                                        output logic fwd);
        fwd = (pend_cnt[a] != 0);
        return shadow_mem[a];
    endfunction

    // sees what the dut samples at each edge
    // a load is looked up before an ack at the same edge frees its entry
    always @(posedge clk) begin : model_update
        logic              exp_fwd;
        logic [DATA_W-1:0] exp_word;
        cycle_cnt = cycle_cnt + 1;
        if (reset === 1'b0) begin
            if (issue && !we) begin
                exp_word = expected_load(addr, exp_fwd);
                exp_data_q.push_back(exp_word);
                exp_fwd_q.push_back(exp_fwd);
                // latency counts from the edge that drove the load
                exp_cycle_q.push_back(cycle_cnt - 1);
            end
            if (issue && we) begin
                shadow_mem[addr] = wdata;
                pend_cnt[addr]   = pend_cnt[addr] + 1;
            end
            if (dut.wb_cyc && dut.wb_ack) begin
                pend_cnt[dut.wb_adr] = pend_cnt[dut.wb_adr] - 1;
                acks_seen = acks_seen + 1;
            end
        end
    end

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("error at %0t: load latency is %0d cycles, expected %0d",
                     $time, got, exp);
        end
    endtask

    // results are stable half a cycle after the edge
    always @(negedge clk) begin
        if (reset === 1'b0 && load_valid === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("error at %0t: load result with no load outstanding", $time);
            end else begin
                check_data(load_data, exp_data_q.pop_front(), "load data");
                check_flag(load_fwd, exp_fwd_q.pop_front(), "load forward flag");
                check_latency(cycle_cnt - exp_cycle_q.pop_front(), LOAD_LATENCY);
                loads_checked++;
            end
        end
    end

    task automatic drive_op(input logic iss, input logic w, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic cmt);
        @(posedge clk);
        issue  <= iss;
        we     <= w;
        addr   <= a;
        wdata  <= d;
        commit <= cmt;
    endtask

    task automatic do_store(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        drive_op(1'b1, 1'b1, a, d, 1'b0);
        stores_driven++;
        uncommitted++;
    endtask

    task automatic do_load(input logic [ADDR_W-1:0] a);
        drive_op(1'b1, 1'b0, a, '0, 1'b0);
        loads_driven++;
    endtask

    task automatic do_commit();
        drive_op(1'b0, 1'b0, '0, '0, 1'b1);
        uncommitted--;
    endtask

    task automatic do_idle();
        drive_op(1'b0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic commit_all();
        while (uncommitted > 0) begin
            do_commit();
        end
        do_idle();
    endtask

    task automatic wait_acks(input int target);
        int waited;
        waited = 0;
        while (acks_seen < target && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (acks_seen < target) begin
            errors++;
            $display("timed out waiting for store drains, %0d of %0d acknowledged",
                     acks_seen, target);
        end
    endtask

    task automatic wait_loads_done();
        int waited;
        waited = 0;
        while (loads_checked != loads_driven && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (loads_checked != loads_driven) begin
            errors++;
            $display("timed out waiting for load results, %0d of %0d returned",
                     loads_checked, loads_driven);
        end
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        $display("test %0d %s: %0d errors", num, name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic test_reset_load();
        do_load(ADDR_W'(random_bits(ADDR_W)));
        do_idle();
        wait_loads_done();
    endtask

    // stores to one address, the last one should be forwarded
    task automatic test_forward(input int n_stores);
        logic [ADDR_W-1:0] a;
        a = ADDR_W'(random_bits(ADDR_W));
        used_addr_q.push_back(a);
        for (int i = 0; i < n_stores; i++) begin
            do_store(a, random_bits(DATA_W));
        end
        do_load(a);
        do_idle();
        wait_loads_done();
    endtask

    task automatic test_drain();
        logic [ADDR_W-1:0] a;
        for (int i = 0; i < 4; i++) begin
            a = ADDR_W'(random_bits(ADDR_W));
            used_addr_q.push_back(a);
            do_store(a, random_bits(DATA_W));
        end
        commit_all();
        wait_acks(stores_driven);
        foreach (used_addr_q[i]) begin
            do_load(used_addr_q[i]);
        end
        do_idle();
        wait_loads_done();
    endtask

    task automatic test_full();
        logic [ADDR_W-1:0] base;
        int                target;
        base = ADDR_W'(random_bits(ADDR_W));
        for (int i = 0; i < SB_DEPTH - 1; i++) begin
            do_store(base + ADDR_W'(i), random_bits(DATA_W));
        end
        do_idle();
        @(negedge clk);
        check_flag(full, 1'b0, "full with one free entry");
        do_store(base + ADDR_W'(SB_DEPTH - 1), random_bits(DATA_W));
        do_idle();
        @(negedge clk);
        check_flag(full, 1'b1, "full with every entry used");
        target = acks_seen + 1;
        do_commit();
        do_idle();
        wait_acks(target);
        check_flag(full, 1'b0, "full after one drain");
        for (int i = 0; i < SB_DEPTH; i++) begin
            do_load(base + ADDR_W'(i));
        end
        commit_all();
        wait_acks(stores_driven);
        wait_loads_done();
    endtask

    // small address window so loads often hit buffered stores
    task automatic test_random();
        logic [1:0]        kind;
        logic [ADDR_W-1:0] a;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            @(negedge clk);
            kind = 2'(random_bits(2));
            a    = ADDR_W'(random_bits(4));
            if (kind == 2'd0 && full === 1'b0) begin
                do_store(a, random_bits(DATA_W));
                // lets full settle before the next decision
                do_idle();
            end else if (kind == 2'd1 && uncommitted > 0) begin
                do_commit();
            end else begin
                do_load(a);
            end
        end
        commit_all();
        wait_acks(stores_driven);
        wait_loads_done();
    endtask

    initial begin
        repeat (TOTAL_OPS * 40) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", TOTAL_OPS * 40);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset  <= 1'b1;
        issue  <= 1'b0;
        we     <= 1'b0;
        addr   <= '0;
        wdata  <= '0;
        commit <= 1'b0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            shadow_mem[i] = '0;
            pend_cnt[i]   = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        test_reset_load();
        end_test(1, "load after reset");
        test_forward(1);
        end_test(2, "store then load forwards");
        test_forward(2);
        end_test(3, "youngest store forwards");
        test_drain();
        end_test(4, "drained stores read from ram");
        test_full();
        end_test(5, "full buffer and release");
        test_random();
        end_test(6, "random mix");

        $display("tests %0d, loads checked %0d, errors %0d", tests_run, loads_checked, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== lsu_top.f ====
hdl/lsu_pkg.sv
hdl/store_buffer.sv
hdl/data_ram.sv
hdl/load_merge.sv
hdl/lsu_top.sv
tb/tb_clock.sv
tb/lsu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module lsu_tb \
    -f lsu_top.f \
    -o lsu_sim

./obj_dir/lsu_sim 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

echo "simulation passed"
